// ==== design/hazard_detect.sv ====
// Hazard unit for the decode stage; flags RAW conflicts and holds control-transfer stalls
`timescale 1ns/1ps

module hazard_detect (
    input  logic              clk,
    input  logic              rst,
    input  logic [3:0]        src_1,
    input  logic [3:0]        src_2,
    input  logic              use_rs,
    input  logic              use_rt,
    input  id_pkg::inflight_t inflight,
    input  logic              xfer,       // Unbubbled B, CALL or RET
    input  logic              pc_update,  // Fetch side has the new PC
    output logic              data_hazard,
    output logic              pc_hazard
);

    import id_pkg::*;

    // True when src hits any live destination
    function automatic logic hits(input logic [3:0] src, input inflight_t fl);
        logic h;
        h = 1'b0;
        if (fl.idex_rd != 4'd0 && src == fl.idex_rd) begin
            h = 1'b1;
        end
        if (fl.exmem_rd != 4'd0 && src == fl.exmem_rd) begin
            h = 1'b1;
        end
        if (fl.memwb_rd != 4'd0 && src == fl.memwb_rd) begin
            h = 1'b1;
        end
        return h;
    endfunction

    logic hit_1;
    logic hit_2;

    assign hit_1 = use_rs & hits(src_1, inflight);
    assign hit_2 = use_rt & hits(src_2, inflight);  // Unused fields never stall

    assign data_hazard = hit_1 | hit_2;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_hazard <= 1'b0;
        end else if (pc_update) begin
            pc_hazard <= 1'b0;  // Release wins over a new transfer
        end else if (xfer) begin
            pc_hazard <= 1'b1;
        end
    end

endmodule

// ==== design/id_control.sv ====
// Opcode decoder for the decode stage; drives the control word, register selects and use flags
`timescale 1ns/1ps

module id_control (
    input  id_pkg::instr_u   instr,
    input  logic             bubble,      // Any hazard this cycle
    output id_pkg::id_ctrl_t ctrl,
    output logic             reg_rt_src,  // Second source from [11:8]
    output logic             stack_sel,   // First source is SP
    output logic             imm8_sel,    // Extend imm8 instead of 4-bit field
    output logic             use_rs,
    output logic             use_rt,
    output logic             xfer         // Control transfer issuing
);

    import id_pkg::*;

    id_ctrl_t ctrl_raw;  // Decode before hazard gating
    opcode_e  op;

    assign op = instr.r_fmt.opcode;

    always_comb begin
        ctrl_raw        = CTRL_BUBBLE;  // Idle unless an opcode says otherwise
        reg_rt_src      = 1'b0;
        stack_sel       = 1'b0;
        imm8_sel        = 1'b0;
        use_rs          = 1'b0;
        use_rt          = 1'b0;
        unique case (op)
            ADD, SUB, AND, NOR: begin
                ctrl_raw.reg_write = 1'b1;
                ctrl_raw.alu_op    = op[2:0];  // ALU code follows opcode
                use_rs             = 1'b1;
                use_rt             = 1'b1;
            end
            SLL, SRL, SRA: begin
                ctrl_raw.reg_write = 1'b1;
                ctrl_raw.alu_src   = 1'b1;     // Shift amount from immediate
                ctrl_raw.alu_op    = op[2:0];
                use_rs             = 1'b1;
            end
            LW: begin
                ctrl_raw.reg_write  = 1'b1;
                ctrl_raw.mem_read   = 1'b1;
                ctrl_raw.mem_to_reg = 1'b1;
                ctrl_raw.alu_src    = 1'b1;    // Base plus offset
                ctrl_raw.alu_op     = 3'b000;
                use_rs              = 1'b1;
            end
            SW: begin
                ctrl_raw.mem_write = 1'b1;
                ctrl_raw.alu_src   = 1'b1;
                ctrl_raw.alu_op    = 3'b000;
                reg_rt_src         = 1'b1;     // Store data lives in [11:8]
                use_rs             = 1'b1;
                use_rt             = 1'b1;
            end
            LHB, LLB: begin
                // Other half of the destination comes in on bus 2
                ctrl_raw.reg_write = 1'b1;
                ctrl_raw.alu_src   = 1'b1;
                ctrl_raw.load_half = 1'b1;
                ctrl_raw.half_spec = (op == LLB);
                reg_rt_src         = 1'b1;
                imm8_sel           = 1'b1;
                use_rt             = 1'b1;
            end
            B: begin
                ctrl_raw.branch = 1'b1;
                imm8_sel        = 1'b1;        // Branch offset
            end
            CALL, RET: begin
                ctrl_raw.call = (op == CALL);
                ctrl_raw.ret  = (op == RET);
                stack_sel     = 1'b1;          // Both touch the stack
                use_rs        = 1'b1;
            end
            HLT: ctrl_raw.halt = 1'b1;
            default: ;                         // NOP keeps the idle word
        endcase
    end

    // Hazard gating
    assign ctrl = bubble ? CTRL_BUBBLE : ctrl_raw;
    assign xfer = ~bubble & (ctrl_raw.branch | ctrl_raw.call | ctrl_raw.ret);

endmodule

// ==== design/id_pkg.sv ====
// Shared types and constants for the decode stage; imported by every design module
package id_pkg;

    // 4-bit instruction set
    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        NOR  = 4'h3,
        SLL  = 4'h4,  // Shifts take a 4-bit immediate
        SRL  = 4'h5,
        SRA  = 4'h6,
        NOP  = 4'h7,
        LW   = 4'h8,
        SW   = 4'h9,
        LHB  = 4'hA,
        LLB  = 4'hB,
        B    = 4'hC,
        CALL = 4'hD,
        RET  = 4'hE,
        HLT  = 4'hF
    } opcode_e;

    // Register-register and shift layout
    typedef struct packed {
        opcode_e    opcode;
        logic [3:0] rd;
        logic [3:0] rs;
        logic [3:0] rt_imm;  // rt or shift amount or LW/SW offset
    } r_fmt_t;

    // Load-half layout
    typedef struct packed {
        opcode_e    opcode;
        logic [3:0] rd;
        logic [7:0] imm8;
    } i_fmt_t;

    // Conditional branch layout
    typedef struct packed {
        opcode_e    opcode;
        logic       spare;
        logic [2:0] cond;
        logic [7:0] offset8;
    } b_fmt_t;

    // Call layout
    typedef struct packed {
        opcode_e     opcode;
        logic [11:0] target12;
    } j_fmt_t;

    // One instruction word, four views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    // Control word toward execute
    typedef struct packed {
        logic       reg_write;
        logic       mem_write;
        logic       mem_read;
        logic       mem_to_reg;
        logic       alu_src;    // 1 selects the extended immediate
        logic [2:0] alu_op;
        logic       branch;
        logic       call;
        logic       ret;
        logic       load_half;
        logic       half_spec;  // 0 for LHB, 1 for LLB
        logic       halt;
    } id_ctrl_t;

    localparam logic [2:0] ALU_OP_NOP = 3'b111;

    // Everything off, ALU idle
    localparam id_ctrl_t CTRL_BUBBLE = '{
        reg_write: 1'b0, mem_write: 1'b0, mem_read: 1'b0, mem_to_reg: 1'b0,
        alu_src: 1'b0, alu_op: ALU_OP_NOP, branch: 1'b0, call: 1'b0,
        ret: 1'b0, load_half: 1'b0, half_spec: 1'b0, halt: 1'b0
    };

    // Operand data toward execute
    typedef struct packed {
        logic [15:0] read_data_1;
        logic [15:0] read_data_2;
        logic [15:0] sign_ext;
        logic [3:0]  dest_reg;
        logic [2:0]  branch_cond;
        logic [11:0] call_target;
        logic [15:0] pc;
        logic        spare;
    } id_operands_t;

    // Writeback port from the last stage
    typedef struct packed {
        logic        we;
        logic [3:0]  addr;
        logic [15:0] data;
    } wb_t;

    // Destinations still in flight, 0 means none
    typedef struct packed {
        logic [3:0] idex_rd;
        logic [3:0] exmem_rd;
        logic [3:0] memwb_rd;
    } inflight_t;

    localparam logic [3:0] SP_REG = 4'd15;  // Stack pointer index

endpackage

// ==== design/id_stage.sv ====
// Instruction-decode stage top; connects decoder, register file, hazard unit and operand path
`timescale 1ns/1ps

module id_stage #(
    parameter logic [15:0] SP_RESET = 16'hFFFF  // Stack pointer after reset
) (
    input  logic                 clk,
    input  logic                 rst,
    input  id_pkg::instr_u       instr,
    input  logic [15:0]          pc,
    input  id_pkg::wb_t          wb,
    input  id_pkg::inflight_t    inflight,
    input  logic                 pc_update,
    output id_pkg::id_ctrl_t     ctrl,
    output id_pkg::id_operands_t ops,
    output logic                 data_hazard,  // Stall request to fetch
    output logic                 pc_hazard
);

    logic        bubble;
    logic        reg_rt_src;
    logic        stack_sel;
    logic        imm8_sel;
    logic        use_rs;
    logic        use_rt;
    logic        xfer;
    logic [3:0]  rd_addr_1;
    logic [3:0]  rd_addr_2;
    logic [15:0] rd_data_1;
    logic [15:0] rd_data_2;

    assign bubble = data_hazard | pc_hazard;

    id_control control_i (
        .instr      (instr),
        .bubble     (bubble),
        .ctrl       (ctrl),
        .reg_rt_src (reg_rt_src),
        .stack_sel  (stack_sel),
        .imm8_sel   (imm8_sel),
        .use_rs     (use_rs),
        .use_rt     (use_rt),
        .xfer       (xfer)
    );

    reg_file #(.SP_RESET(SP_RESET)) reg_file_i (
        .clk       (clk),
        .rst       (rst),
        .wb        (wb),
        .rd_addr_1 (rd_addr_1),
        .rd_addr_2 (rd_addr_2),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2)
    );

    hazard_detect hazard_i (
        .clk         (clk),
        .rst         (rst),
        .src_1       (rd_addr_1),  // Compare the addresses actually read
        .src_2       (rd_addr_2),
        .use_rs      (use_rs),
        .use_rt      (use_rt),
        .inflight    (inflight),
        .xfer        (xfer),
        .pc_update   (pc_update),
        .data_hazard (data_hazard),
        .pc_hazard   (pc_hazard)
    );

    operand_path operand_i (
        .instr      (instr),
        .pc         (pc),
        .reg_rt_src (reg_rt_src),
        .stack_sel  (stack_sel),
        .imm8_sel   (imm8_sel),
        .rd_addr_1  (rd_addr_1),
        .rd_addr_2  (rd_addr_2),
        .rd_data_1  (rd_data_1),
        .rd_data_2  (rd_data_2),
        .ops        (ops)
    );

endmodule

// ==== design/operand_path.sv ====
// Operand path of the decode stage; picks register addresses, extends immediates, packs operands
`timescale 1ns/1ps

module operand_path (
    input  id_pkg::instr_u       instr,
    input  logic [15:0]          pc,
    input  logic                 reg_rt_src,
    input  logic                 stack_sel,
    input  logic                 imm8_sel,
    output logic [3:0]           rd_addr_1,
    output logic [3:0]           rd_addr_2,
    input  logic [15:0]          rd_data_1,
    input  logic [15:0]          rd_data_2,
    output id_pkg::id_operands_t ops
);

    import id_pkg::*;

    logic [15:0] imm_ext;

    // Register address muxes
    assign rd_addr_1 = stack_sel  ? SP_REG : instr.r_fmt.rs;
    assign rd_addr_2 = reg_rt_src ? instr.r_fmt.rd : instr.r_fmt.rt_imm;  // SW and LHB/LLB

    // Sign extension
    assign imm_ext = imm8_sel ? {{8{instr.i_fmt.imm8[7]}}, instr.i_fmt.imm8}
                              : {{12{instr.r_fmt.rt_imm[3]}}, instr.r_fmt.rt_imm};

    always_comb begin
        ops.read_data_1 = rd_data_1;
        ops.read_data_2 = rd_data_2;
        ops.sign_ext    = imm_ext;
        ops.dest_reg    = instr.i_fmt.rd;         // [11:8]
        ops.branch_cond = instr.b_fmt.cond;
        ops.call_target = instr.j_fmt.target12;
        ops.pc          = pc;                     // Straight through
        ops.spare       = 1'b0;
    end

endmodule

// ==== design/reg_file.sv ====
// Sixteen-entry register file for the decode stage; two combinational reads, one clocked write
`timescale 1ns/1ps

module reg_file #(
    parameter logic [15:0] SP_RESET = 16'hFFFF
) (
    input  logic        clk,
    input  logic        rst,
    input  id_pkg::wb_t wb,
    input  logic [3:0]  rd_addr_1,
    input  logic [3:0]  rd_addr_2,
    output logic [15:0] rd_data_1,
    output logic [15:0] rd_data_2
);

    import id_pkg::*;

    logic [15:0] regs [1:15];  // Register 0 has no storage

    function automatic logic [15:0] read_reg(input logic [3:0] addr);
        logic [15:0] val;
        if (addr == 4'd0) begin
            val = '0;                 // Hardwired zero
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 16; i++) begin
                regs[i] <= (4'(i) == SP_REG) ? SP_RESET : 16'h0000;  // SP starts at top
            end
        end else if (wb.we && wb.addr != 4'd0) begin
            regs[wb.addr] <= wb.data;  // Writes to r0 dropped
        end
    end

    // No write-through, new value shows next cycle
    assign rd_data_1 = read_reg(rd_addr_1);
    assign rd_data_2 = read_reg(rd_addr_2);

endmodule

// ==== dv/id_stage_checker.sv ====
// Assertion module bound into the decode stage; checks bubble, reset and data-hazard rules
`timescale 1ns/1ps

module id_stage_checker (
    input logic              clk,
    input logic              rst,
    input id_pkg::id_ctrl_t  ctrl,
    input id_pkg::inflight_t inflight,
    input logic              data_hazard,
    input logic              pc_hazard
);

    localparam logic [13:0] BUBBLE_WORD = 14'b00000_111_000000;  // Only alu_op set

    int fail_count = 0;  // Failed assertions so far

    // Falling edge, inputs are stable there
    bubble_on_hazard: assert property (@(negedge clk) disable iff (rst)
        (data_hazard || pc_hazard) |-> (ctrl == BUBBLE_WORD))
        else begin
            $error("ctrl is not a bubble while a hazard is raised");
            fail_count++;
        end

    pc_hazard_after_reset: assert property (@(negedge clk) rst |=> !pc_hazard)
        else begin
            $error("pc_hazard is set in the cycle after reset");
            fail_count++;
        end

    no_hazard_when_clear: assert property (@(negedge clk) (inflight == '0) |-> !data_hazard)
        else begin
            $error("data_hazard is raised with nothing in flight");
            fail_count++;
        end

endmodule

// ==== dv/id_stage_monitor.sv ====
// Output checker for the decode stage testbench; compares DUT outputs with the current table row
`timescale 1ns/1ps

module id_stage_monitor (
    input  logic                 clk,
    input  logic                 check_en,      // A row is on the inputs
    input  logic [95:0]          name,
    input  logic [15:0]          instr,
    input  logic [15:0]          pc,
    input  id_pkg::id_ctrl_t     exp_ctrl,
    input  logic [15:0]          exp_rd_1,
    input  logic [15:0]          exp_rd_2,
    input  logic [15:0]          exp_ext,
    input  logic                 exp_data_haz,
    input  logic                 exp_pc_haz,
    input  id_pkg::id_ctrl_t     ctrl,
    input  id_pkg::id_operands_t ops,
    input  logic                 data_hazard,
    input  logic                 pc_hazard,
    output int                   checks,
    output int                   errors,
    output int                   steps_done
);

    int n_checks = 0;
    int n_errors = 0;
    int n_steps  = 0;

    assign checks     = n_checks;
    assign errors     = n_errors;
    assign steps_done = n_steps;

    task automatic compare(input string field, input logic [15:0] exp, input logic [15:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("** Error %s %s: expected %h, actual %h", string'(name), field, exp, act);
        end
    endtask

    // Inputs change on the rising edge, so the falling edge sees settled outputs
    always @(negedge clk) begin
        if (check_en) begin
            compare("ctrl", 16'(exp_ctrl), 16'(ctrl));
            compare("read_data_1", exp_rd_1, ops.read_data_1);
            compare("read_data_2", exp_rd_2, ops.read_data_2);
            compare("sign_ext", exp_ext, ops.sign_ext);
            compare("data_hazard", 16'(exp_data_haz), 16'(data_hazard));
            compare("pc_hazard", 16'(exp_pc_haz), 16'(pc_hazard));
            compare("dest_reg", 16'(instr[11:8]), 16'(ops.dest_reg));        // Field passthrough
            compare("branch_cond", 16'(instr[10:8]), 16'(ops.branch_cond));
            compare("call_target", 16'(instr[11:0]), 16'(ops.call_target));
            compare("pc", pc, ops.pc);
            compare("spare", 16'h0000, 16'(ops.spare));  // Unused bit stays low
            n_steps++;
        end
    end

endmodule

// ==== dv/id_stage_tb.sv ====
// Testbench top for the decode stage; builds a stimulus table, applies it row by row, reports
`timescale 1ns/1ps

module id_stage_tb;

    import id_pkg::*;

    localparam logic [15:0] SP_RESET = 16'hEFFE;            // Not the default, proves the pass-down
    localparam logic [13:0] BUBBLE   = 14'b00000_111_000000; // All off, ALU idle
    localparam wb_t         NO_WB    = '0;
    localparam inflight_t   CLEAR    = '0;

    // One table row, inputs then expected values
    typedef struct packed {
        logic [95:0] name;  // Up to 12 characters
        instr_u      instr;
        logic [15:0] pc;
        wb_t         wb;
        inflight_t   inflight;
        logic        pc_update;
        id_ctrl_t    ctrl;
        logic [15:0] rd_1;
        logic [15:0] rd_2;
        logic [15:0] ext;
        logic        data_haz;
        logic        pc_haz;
    } step_t;

    logic         clk = 1'b0;
    logic         rst;
    id_ctrl_t     ctrl;
    id_operands_t ops;
    logic         data_hazard;
    logic         pc_hazard;
    step_t        cur;          // Row on the DUT inputs
    logic         check_en;
    int           checks;
    int           errors;
    int           steps_done;
    step_t        steps [$];
    logic [15:0]  shadow [16];  // Register model

    always #10 clk = ~clk;

    id_stage #(.SP_RESET(SP_RESET)) id_stage_i (
        .clk         (clk),
        .rst         (rst),
        .instr       (cur.instr),
        .pc          (cur.pc),
        .wb          (cur.wb),
        .inflight    (cur.inflight),
        .pc_update   (cur.pc_update),
        .ctrl        (ctrl),
        .ops         (ops),
        .data_hazard (data_hazard),
        .pc_hazard   (pc_hazard)
    );

    id_stage_monitor monitor_i (
        .clk          (clk),
        .check_en     (check_en),
        .name         (cur.name),
        .instr        (cur.instr),
        .pc           (cur.pc),
        .exp_ctrl     (cur.ctrl),
        .exp_rd_1     (cur.rd_1),
        .exp_rd_2     (cur.rd_2),
        .exp_ext      (cur.ext),
        .exp_data_haz (cur.data_haz),
        .exp_pc_haz   (cur.pc_haz),
        .ctrl         (ctrl),
        .ops          (ops),
        .data_hazard  (data_hazard),
        .pc_hazard    (pc_hazard),
        .checks       (checks),
        .errors       (errors),
        .steps_done   (steps_done)
    );

    bind id_stage id_stage_checker checker_i (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (ctrl),
        .inflight    (inflight),
        .data_hazard (data_hazard),
        .pc_hazard   (pc_hazard)
    );

    // Unbubbled control word per opcode
    function automatic logic [13:0] ctrl_for_opcode(input logic [3:0] op);
        logic [13:0] w;
        case (op)
            4'h0: w = 14'b10000_000_000000;  // ADD
            4'h1: w = 14'b10000_001_000000;
            4'h2: w = 14'b10000_010_000000;
            4'h3: w = 14'b10000_011_000000;  // NOR
            4'h4: w = 14'b10001_100_000000;  // SLL
            4'h5: w = 14'b10001_101_000000;
            4'h6: w = 14'b10001_110_000000;
            4'h7: w = 14'b00000_111_000000;  // NOP
            4'h8: w = 14'b10111_000_000000;  // LW
            4'h9: w = 14'b01001_000_000000;  // SW
            4'hA: w = 14'b10001_111_000100;  // LHB, half_spec 0
            4'hB: w = 14'b10001_111_000110;  // LLB, half_spec 1
            4'hC: w = 14'b00000_111_100000;  // B
            4'hD: w = 14'b00000_111_010000;  // CALL
            4'hE: w = 14'b00000_111_001000;  // RET
            4'hF: w = 14'b00000_111_000001;  // HLT
        endcase
        return w;
    endfunction

    // LHB, LLB and B use imm8
    function automatic logic [15:0] extend_imm(input logic [15:0] ins);
        if (ins[15:12] inside {4'hA, 4'hB, 4'hC}) begin
            return {{8{ins[7]}}, ins[7:0]};
        end
        return {{12{ins[3]}}, ins[3:0]};
    endfunction

    // Stack ops read SP first
    function automatic logic [3:0] first_src(input logic [15:0] ins);
        return (ins[15:12] inside {4'hD, 4'hE}) ? 4'hF : ins[7:4];
    endfunction

    function automatic logic [3:0] second_src(input logic [15:0] ins);
        return (ins[15:12] inside {4'h9, 4'hA, 4'hB}) ? ins[11:8] : ins[3:0];  // SW, LHB, LLB
    endfunction

    task automatic add_step(input logic [95:0] name, input logic [15:0] ins, input wb_t wr,
                            input inflight_t fl, input logic pcu, input logic dh,
                            input logic ph);
        step_t s;
        s.name      = name;
        s.instr     = ins;
        s.pc        = 16'($urandom);
        s.wb        = wr;
        s.inflight  = fl;
        s.pc_update = pcu;
        s.ctrl      = (dh || ph) ? BUBBLE : ctrl_for_opcode(ins[15:12]);
        s.rd_1      = shadow[first_src(ins)];
        s.rd_2      = shadow[second_src(ins)];
        s.ext       = extend_imm(ins);
        s.data_haz  = dh;
        s.pc_haz    = ph;
        steps.push_back(s);
        if (wr.we && wr.addr != 4'd0) begin
            shadow[wr.addr] = wr.data;  // Seen from the next row on
        end
    endtask

    initial begin
        logic [15:0] v;
        int          waited;
        rst       = 1'b1;
        cur       = '0;
        cur.instr = 16'hC000;  // Branch held through reset must not leave pc_hazard set
        check_en  = 1'b0;
        void'($urandom(32'h9763_c983));
        for (int r = 0; r < 16; r++) begin
            shadow[4'(r)] = (r == 15) ? SP_RESET : 16'h0000;
        end
        // Reset contents, then a CALL released by pc_update
        add_step("rst_regs", 16'h0123, NO_WB, CLEAR, 1'b0, 1'b0, 1'b0);
        add_step("rst_call", 16'hD123, NO_WB, CLEAR, 1'b0, 1'b0, 1'b0);
        add_step("call_hold", 16'h7000, NO_WB, CLEAR, 1'b1, 1'b0, 1'b1);
        // Write r, read back r-1 and the stale r
        for (int r = 1; r < 16; r++) begin
            v = 16'($urandom);
            add_step("wb_read", {4'h0, 4'h1, 4'(r - 1), 4'(r)}, {1'b1, 4'(r), v},
                     CLEAR, 1'b0, 1'b0, 1'b0);
        end
        add_step("wb_r0_write", 16'h0FE0, {1'b1, 4'h0, 16'hBEEF}, CLEAR, 1'b0, 1'b0, 1'b0);
        add_step("wb_r0_read", 16'h01F0, NO_WB, CLEAR, 1'b0, 1'b0, 1'b0);
        // Every opcode once, transfers need a release
        for (int op = 0; op < 16; op++) begin
            add_step("decode", {4'(op), 12'($urandom)}, NO_WB, CLEAR, 1'b0, 1'b0, 1'b0);
            if (op >= 12 && op <= 14) begin
                add_step("xfer_release", 16'h7000, NO_WB, CLEAR, 1'b1, 1'b0, 1'b1);
            end
        end
        add_step("sll_neg_imm", 16'h4128, NO_WB, CLEAR, 1'b0, 1'b0, 1'b0);
        add_step("sra_pos_imm", 16'h6347, NO_WB, CLEAR, 1'b0, 1'b0, 1'b0);
        add_step("llb_neg_imm", 16'hB580, NO_WB, CLEAR, 1'b0, 1'b0, 1'b0);
        add_step("lhb_pos_imm", 16'hA67F, NO_WB, CLEAR, 1'b0, 1'b0, 1'b0);
        add_step("sw_sources", 16'h9A3C, NO_WB, CLEAR, 1'b0, 1'b0, 1'b0);
        add_step("b_neg_imm", 16'hC59C, NO_WB, CLEAR, 1'b0, 1'b0, 1'b0);
        add_step("b_release", 16'h7000, NO_WB, CLEAR, 1'b1, 1'b0, 1'b1);
        // ADD r1, r2, r3 against each in-flight slot
        add_step("haz_idex", 16'h0123, NO_WB, {4'h2, 4'h0, 4'h0}, 1'b0, 1'b1, 1'b0);
        add_step("haz_exmem", 16'h0123, NO_WB, {4'h0, 4'h3, 4'h0}, 1'b0, 1'b1, 1'b0);
        add_step("haz_memwb", 16'h0123, NO_WB, {4'h0, 4'h0, 4'h2}, 1'b0, 1'b1, 1'b0);
        add_step("haz_shift", 16'h4123, NO_WB, {4'h3, 4'h0, 4'h0}, 1'b0, 1'b0, 1'b0);
        add_step("haz_lhb_rs", 16'hA123, NO_WB, {4'h2, 4'h0, 4'h0}, 1'b0, 1'b0, 1'b0);
        add_step("haz_call_sp", 16'hD000, NO_WB, {4'h0, 4'h0, 4'hF}, 1'b0, 1'b1, 1'b0);
        add_step("haz_cleared", 16'h0123, NO_WB, CLEAR, 1'b0, 1'b0, 1'b0);
        // Branch hold, a bubbled branch, then release
        add_step("pc_branch", 16'hC203, NO_WB, CLEAR, 1'b0, 1'b0, 1'b0);
        add_step("pc_hold", 16'h0123, NO_WB, CLEAR, 1'b0, 1'b0, 1'b1);
        add_step("pc_hold_b", 16'hC000, NO_WB, CLEAR, 1'b0, 1'b0, 1'b1);
        add_step("pc_update", 16'h0123, NO_WB, CLEAR, 1'b1, 1'b0, 1'b1);
        add_step("pc_cleared", 16'h0123, NO_WB, CLEAR, 1'b0, 1'b0, 1'b0);

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        cur <= '0;
        foreach (steps[i]) begin
            @(posedge clk);
            cur      <= steps[i];
            check_en <= 1'b1;
        end
        @(posedge clk);
        check_en <= 1'b0;
        waited = 0;
        while (steps_done < steps.size() && waited < 20) begin  // Last compare is on a falling edge
            @(posedge clk);
            waited++;
        end
        if (steps_done < steps.size()) begin
            $display("Timed out waiting for the monitor to check every row");
        end
        $display("Checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, id_stage_i.checker_i.fail_count);
        if (errors == 0 && id_stage_i.checker_i.fail_count == 0 && steps_done == steps.size()) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
design/id_pkg.sv
design/id_control.sv
design/reg_file.sv
design/hazard_detect.sv
design/operand_path.sv
design/id_stage.sv
dv/id_stage_checker.sv
dv/id_stage_monitor.sv
dv/id_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --assert -f files.f --top-module id_stage_tb -o id_stage_sim \
    && ./obj_dir/id_stage_sim +verilator+error+limit+1000 | tee /dev/stderr \
    | grep -q "TESTBENCH PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
